// ==== ch_buf.sv ====
`timescale 1ns/100ps

module ch_buf (
   input  logic                      wb_clk_i,
   // source region, upper half of the array.
   input  logic                      src_we_i,
   input  logic [ch_pkg::addr_w-1:0] src_waddr_i,
   input  logic [ch_pkg::word_w-1:0] src_wdata_i,
   input  logic [ch_pkg::addr_w-1:0] src_raddr_i,
   output logic [ch_pkg::word_w-1:0] src_rdata_o,
   output logic                      src_rallow_o,
   // destination region, lower half of the array.
   input  logic                      dst_we_i,
   input  logic [ch_pkg::addr_w-1:0] dst_waddr_i,
   input  logic [ch_pkg::word_w-1:0] dst_wdata_i,
   input  logic [ch_pkg::addr_w-1:0] dst_raddr_i,
   output logic [ch_pkg::word_w-1:0] dst_rdata_o,
   output logic                      dst_rallow_o
);

   logic [ch_pkg::word_w-1:0] mem [0:(1 << (ch_pkg::addr_w + 1))-1];

   logic [ch_pkg::addr_w:0]   a_addr;
   logic [ch_pkg::addr_w:0]   b_addr;
   logic [ch_pkg::word_w-1:0] a_q;
   logic [ch_pkg::word_w-1:0] b_q;

   // --------------------
   // port arbitration
   // --------------------
   // port A writes the source region, else it reads the destination region.
   assign a_addr = src_we_i ? {1'b1, src_waddr_i} : {1'b0, dst_raddr_i};
   // port B writes the destination region, else it reads the source region.
   assign b_addr = dst_we_i ? {1'b0, dst_waddr_i} : {1'b1, src_raddr_i};

   assign dst_rallow_o = !src_we_i;           // destination reads share port A.
   assign src_rallow_o = !dst_we_i;           // source reads share port B.

   // --------------------
   // storage
   // --------------------
   // the two ports always write different halves, so one block covers both.
   always_ff @(posedge wb_clk_i)
   begin
      if (src_we_i)
         mem[a_addr] <= src_wdata_i;
      else
         a_q <= mem[a_addr];              // output keeps its value during a write.
      if (dst_we_i)
         mem[b_addr] <= dst_wdata_i;
      else
         b_q <= mem[b_addr];
   end

   assign dst_rdata_o = a_q;
   assign src_rdata_o = b_q;

endmodule

// ==== ch_dma_chan.sv ====
`timescale 1ns/100ps

module ch_dma_chan (
   input  logic        wb_clk_i,
   input  logic        m_reset0,
   // stream port 0, into the source FIFO.
   input  logic        ss_xfer0_i,
   input  logic        ss_last0_i,
   input  logic [31:0] wbs_dat_o0_i,
   input  logic [31:0] wbs_dat64_o0_i,
   output logic        ss_stop0_o,
   output logic        ss_start0_o,
   // stream port 1, out of the destination FIFO.
   input  logic        ss_xfer1_i,
   output logic        ss_stop1_o,
   output logic        ss_start1_o,
   output logic        ss_end1_o,
   output logic [31:0] wbs_dat_i1_o,
   output logic [31:0] wbs_dat64_i1_o,
   // processing module side.
   input  logic        m_src_getn0_i,
   output logic [63:0] m_src0_o,
   output logic        m_src_last0_o,
   output logic        m_src_empty0_o,
   output logic        m_src_almost_empty0_o,
   input  logic        m_dst_putn0_i,
   input  logic [63:0] m_dst0_i,
   input  logic        m_dst_last0_i,
   input  logic        m_endn0_i,
   output logic        m_dst_full0_o,
   output logic        m_dst_almost_full0_o,
   output logic [15:0] ocnt0_o
);

   logic                      src_we;
   logic                      dst_we;
   logic                      src_rallow;
   logic                      dst_rallow;
   logic [ch_pkg::addr_w-1:0] src_waddr;
   logic [ch_pkg::addr_w-1:0] src_raddr;
   logic [ch_pkg::addr_w-1:0] dst_waddr;
   logic [ch_pkg::addr_w-1:0] dst_raddr;
   logic [ch_pkg::word_w-1:0] src_wdata;
   logic [ch_pkg::word_w-1:0] src_rdata;
   logic [ch_pkg::word_w-1:0] dst_wdata;
   logic [ch_pkg::word_w-1:0] dst_rdata;

   ch_ingress ingress_i (
      .wb_clk_i              (wb_clk_i),
      .m_reset0              (m_reset0),
      .ss_xfer0_i            (ss_xfer0_i),
      .ss_last0_i            (ss_last0_i),
      .wbs_dat_o0_i          (wbs_dat_o0_i),
      .wbs_dat64_o0_i        (wbs_dat64_o0_i),
      .m_src_getn0_i         (m_src_getn0_i),
      .src_rallow_i          (src_rallow),
      .src_rdata_i           (src_rdata),
      .ss_stop0_o            (ss_stop0_o),
      .ss_start0_o           (ss_start0_o),
      .src_we_o              (src_we),
      .src_waddr_o           (src_waddr),
      .src_wdata_o           (src_wdata),
      .src_raddr_o           (src_raddr),
      .m_src0_o              (m_src0_o),
      .m_src_last0_o         (m_src_last0_o),
      .m_src_empty0_o        (m_src_empty0_o),
      .m_src_almost_empty0_o (m_src_almost_empty0_o)
   );

   ch_buf buf_i (
      .wb_clk_i     (wb_clk_i),
      .src_we_i     (src_we),
      .src_waddr_i  (src_waddr),
      .src_wdata_i  (src_wdata),
      .src_raddr_i  (src_raddr),
      .src_rdata_o  (src_rdata),
      .src_rallow_o (src_rallow),
      .dst_we_i     (dst_we),
      .dst_waddr_i  (dst_waddr),
      .dst_wdata_i  (dst_wdata),
      .dst_raddr_i  (dst_raddr),
      .dst_rdata_o  (dst_rdata),
      .dst_rallow_o (dst_rallow)
   );

   ch_egress egress_i (
      .wb_clk_i             (wb_clk_i),
      .m_reset0             (m_reset0),
      .m_dst_putn0_i        (m_dst_putn0_i),
      .m_dst0_i             (m_dst0_i),
      .m_dst_last0_i        (m_dst_last0_i),
      .m_endn0_i            (m_endn0_i),
      .ss_xfer1_i           (ss_xfer1_i),
      .dst_rallow_i         (dst_rallow),
      .dst_rdata_i          (dst_rdata),
      .dst_we_o             (dst_we),
      .dst_waddr_o          (dst_waddr),
      .dst_wdata_o          (dst_wdata),
      .dst_raddr_o          (dst_raddr),
      .m_dst_full0_o        (m_dst_full0_o),
      .m_dst_almost_full0_o (m_dst_almost_full0_o),
      .ss_stop1_o           (ss_stop1_o),
      .ss_start1_o          (ss_start1_o),
      .ss_end1_o            (ss_end1_o),
      .wbs_dat_i1_o         (wbs_dat_i1_o),
      .wbs_dat64_i1_o       (wbs_dat64_i1_o),
      .ocnt0_o              (ocnt0_o)
   );

endmodule

// ==== ch_egress.sv ====
`timescale 1ns/100ps

module ch_egress (
   input  logic                      wb_clk_i,
   input  logic                      m_reset0,
   input  logic                      m_dst_putn0_i,
   input  logic [63:0]               m_dst0_i,
   input  logic                      m_dst_last0_i,
   input  logic                      m_endn0_i,
   input  logic                      ss_xfer1_i,
   input  logic                      dst_rallow_i,
   input  logic [ch_pkg::word_w-1:0] dst_rdata_i,
   output logic                      dst_we_o,
   output logic [ch_pkg::addr_w-1:0] dst_waddr_o,
   output logic [ch_pkg::word_w-1:0] dst_wdata_o,
   output logic [ch_pkg::addr_w-1:0] dst_raddr_o,
   output logic                      m_dst_full0_o,
   output logic                      m_dst_almost_full0_o,
   output logic                      ss_stop1_o,
   output logic                      ss_start1_o,
   output logic                      ss_end1_o,
   output logic [31:0]               wbs_dat_i1_o,
   output logic [31:0]               wbs_dat64_i1_o,
   output logic [15:0]               ocnt0_o
);

   ch_pkg::ch_word_u wr_word;
   ch_pkg::ch_word_u rd_word;
   ch_pkg::ch_word_u rd_hold;
   logic             xfer_ok;
   logic             xfer_q;
   logic             end_q;                   // tag of the last delivered word.
   logic             dst_empty;
   logic             dst_half;

   // no further reads once the tagged word has gone out.
   ch_fifo_ctrl dst_ctrl_i (
      .wb_clk_i       (wb_clk_i),
      .m_reset0       (m_reset0),
      .wr_i           (!m_dst_putn0_i),
      .rd_i           (ss_xfer1_i && !ss_end1_o),
      .rallow_i       (dst_rallow_i),
      .waddr_o        (dst_waddr_o),
      .raddr_o        (dst_raddr_o),
      .wr_ok_o        (dst_we_o),
      .rd_ok_o        (xfer_ok),
      .empty_o        (dst_empty),
      .full_o         (m_dst_full0_o),
      .almost_empty_o (ss_stop1_o),
      .almost_full_o  (m_dst_almost_full0_o),
      .half_o         (dst_half)
   );

   always_comb
   begin
      wr_word.m.tag = {m_dst_last0_i, 7'b0};
      wr_word.m.d64 = m_dst0_i;
   end
   assign dst_wdata_o = wr_word;

   // --------------------
   // stream-1 read side
   // --------------------
   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset0)
      begin
         xfer_q <= 1'b0;
         end_q  <= 1'b0;
      end
      else
      begin
         xfer_q <= xfer_ok;
         if (xfer_q)
            end_q <= rd_word.s.tag[7];
      end
      if (xfer_q)
         rd_hold <= dst_rdata_i;
   end

   assign rd_word        = xfer_q ? ch_pkg::ch_word_u'(dst_rdata_i) : rd_hold;
   assign wbs_dat64_i1_o = rd_word.s.hi32;
   assign wbs_dat_i1_o   = rd_word.s.lo32;
   assign ss_end1_o      = xfer_q ? rd_word.s.tag[7] : end_q;

   // flush a short tail once the module signals its end.
   assign ss_start1_o = dst_half || (!m_endn0_i && !dst_empty);

   // counts accepted results that carry no last tag.
   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset0)
         ocnt0_o <= '0;
      else if (dst_we_o && !m_dst_last0_i)
         ocnt0_o <= ocnt0_o + 1'b1;
   end

endmodule

// ==== ch_fifo_ctrl.sv ====
`timescale 1ns/100ps

module ch_fifo_ctrl (
   input  logic                      wb_clk_i,
   input  logic                      m_reset0,
   input  logic                      wr_i,        // write request from the producer.
   input  logic                      rd_i,        // read request from the consumer.
   input  logic                      rallow_i,    // the buffer port is free for a read.
   output logic [ch_pkg::addr_w-1:0] waddr_o,
   output logic [ch_pkg::addr_w-1:0] raddr_o,
   output logic                      wr_ok_o,
   output logic                      rd_ok_o,
   output logic                      empty_o,
   output logic                      full_o,
   output logic                      almost_empty_o,
   output logic                      almost_full_o,
   output logic                      half_o
);

   logic [ch_pkg::addr_w-1:0] wptr;
   logic [ch_pkg::addr_w-1:0] rptr;
   logic [ch_pkg::addr_w:0]   count;          // occupancy, 0 up to depth.

   // --------------------
   // request qualification
   // --------------------
   assign wr_ok_o = wr_i && !full_o;          // a write into a full region is dropped.
   assign rd_ok_o = rd_i && !empty_o && rallow_i;

   // pointers wrap on their own at the region size.
   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset0)
      begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end
      else
      begin
         if (wr_ok_o)
            wptr <= wptr + 1'b1;
         if (rd_ok_o)
            rptr <= rptr + 1'b1;
         unique case ({wr_ok_o, rd_ok_o})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;      // idle, or a write and a read cancel out.
         endcase
      end
   end

   assign waddr_o = wptr;
   assign raddr_o = rptr;

   // --------------------
   // level flags
   // --------------------
   assign empty_o        = (count == '0);
   assign full_o         = (count == ch_pkg::depth);
   assign almost_empty_o = (count <= ch_pkg::almost_empty_lvl);
   assign almost_full_o  = (count >= ch_pkg::almost_full_lvl);
   assign half_o         = (count >= ch_pkg::half_lvl);

endmodule

// ==== ch_ingress.sv ====
`timescale 1ns/100ps

module ch_ingress (
   input  logic                      wb_clk_i,
   input  logic                      m_reset0,
   input  logic                      ss_xfer0_i,
   input  logic                      ss_last0_i,
   input  logic [31:0]               wbs_dat_o0_i,
   input  logic [31:0]               wbs_dat64_o0_i,
   input  logic                      m_src_getn0_i,
   input  logic                      src_rallow_i,
   input  logic [ch_pkg::word_w-1:0] src_rdata_i,
   output logic                      ss_stop0_o,
   output logic                      ss_start0_o,
   output logic                      src_we_o,
   output logic [ch_pkg::addr_w-1:0] src_waddr_o,
   output logic [ch_pkg::word_w-1:0] src_wdata_o,
   output logic [ch_pkg::addr_w-1:0] src_raddr_o,
   output logic [63:0]               m_src0_o,
   output logic                      m_src_last0_o,
   output logic                      m_src_empty0_o,
   output logic                      m_src_almost_empty0_o
);

   ch_pkg::ch_word_u wr_word;
   ch_pkg::ch_word_u rd_word;
   ch_pkg::ch_word_u rd_hold;
   logic             get_ok;
   logic             get_q;                   // RAM output holds a fresh word.
   logic             src_half;
   logic             src_almost_full;

   ch_fifo_ctrl src_ctrl_i (
      .wb_clk_i       (wb_clk_i),
      .m_reset0       (m_reset0),
      .wr_i           (ss_xfer0_i),
      .rd_i           (!m_src_getn0_i),
      .rallow_i       (src_rallow_i),
      .waddr_o        (src_waddr_o),
      .raddr_o        (src_raddr_o),
      .wr_ok_o        (src_we_o),
      .rd_ok_o        (get_ok),
      .empty_o        (m_src_empty0_o),
      .full_o         (),
      .almost_empty_o (m_src_almost_empty0_o),
      .almost_full_o  (src_almost_full),
      .half_o         (src_half)
   );

   // stream word in, as two halves and a tag.
   always_comb
   begin
      wr_word.s.tag  = {ss_last0_i, 7'b0};
      wr_word.s.hi32 = wbs_dat64_o0_i;
      wr_word.s.lo32 = wbs_dat_o0_i;
   end
   assign src_wdata_o = wr_word;

   // the RAM output moves on idle cycles, so the last delivered word is kept.
   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset0)
         get_q <= 1'b0;
      else
         get_q <= get_ok;
      if (get_q)
         rd_hold <= src_rdata_i;
   end

   assign rd_word       = get_q ? ch_pkg::ch_word_u'(src_rdata_i) : rd_hold;
   assign m_src0_o      = rd_word.m.d64;
   assign m_src_last0_o = rd_word.m.tag[7];

   assign ss_stop0_o  = src_almost_full;
   assign ss_start0_o = !src_half;            // room for a burst below half.

endmodule

// ==== ch_pkg.sv ====
package ch_pkg;

   // --------------------
   // buffer geometry
   // --------------------
   localparam int addr_w = 8;                 // address width of one FIFO region.
   localparam int word_w = 72;                // tag byte plus a 64-bit payload.

   // fill levels are compared against a count that is one bit wider than a pointer.
   localparam logic [addr_w:0] depth            = 9'd256;  // words per region.
   localparam logic [addr_w:0] almost_full_lvl  = 9'd254;  // at or above this count.
   localparam logic [addr_w:0] almost_empty_lvl = 9'd1;    // at or below this count.
   localparam logic [addr_w:0] half_lvl         = 9'd128;  // at or above this count.

   // --------------------
   // buffer word
   // --------------------
   // the stream engine moves a word as two 32-bit halves.
   typedef struct packed {
      logic [7:0]  tag;                       // bit 7 is the last flag, the rest is zero.
      logic [31:0] hi32;                      // upper half, the 64-bit data lane.
      logic [31:0] lo32;                      // lower half, the 32-bit data lane.
   } ch_word_t;

   // the processing module sees the same bits as one 64-bit value.
   typedef struct packed {
      logic [7:0]  tag;                       // same tag byte as the stream view.
      logic [63:0] d64;                       // hi32 and lo32 concatenated.
   } ch_mword_t;

   typedef union packed {
      ch_word_t  s;                           // stream view.
      ch_mword_t m;                           // module view.
   } ch_word_u;

endpackage

// ==== compile.f ====
ch_pkg.sv
ch_fifo_ctrl.sv
ch_buf.sv
ch_ingress.sv
ch_egress.sv
ch_dma_chan.sv
tb_chk.sv
tb_clkgen.sv
tb_monitor.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then judge the run from its log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_top -f compile.f -o tb_sim \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation stopped with an error"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

// ==== tb_chk.sv ====
`timescale 1ns/100ps

module tb_chk (
   input logic       clk_i,
   input logic       rst_i,
   input logic       empty_i,
   input logic       full_i,
   input logic [7:0] waddr_i,
   input logic [7:0] raddr_i,
   input logic [8:0] count_i
);

   // pointers and occupancy live in separate registers and must stay in step.
   ptr_gap_matches_count: assert property (@(posedge clk_i) disable iff (rst_i)
      (waddr_i - raddr_i) == count_i[7:0])
      else $error("FIFO pointer distance does not match the occupancy count.");

   count_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
      count_i <= 9'd256)
      else $error("FIFO occupancy count is above the region depth.");

   full_blocks_write: assert property (@(posedge clk_i) disable iff (rst_i)
      full_i |=> $stable(waddr_i))
      else $error("FIFO write pointer moved while the region was full.");

   empty_blocks_read: assert property (@(posedge clk_i) disable iff (rst_i)
      empty_i |=> $stable(raddr_i))
      else $error("FIFO read pointer moved while the region was empty.");

endmodule

// one checker per FIFO region, so both controls are covered.
bind ch_fifo_ctrl tb_chk chk_i (
   .clk_i   (wb_clk_i),
   .rst_i   (m_reset0),
   .empty_i (empty_o),
   .full_i  (full_o),
   .waddr_i (waddr_o),
   .raddr_i (raddr_o),
   .count_i (count)
);

// ==== tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
   output logic clk_o,
   output logic rst_o
);

   localparam int half_period = 4;            // 8 ns clock.
   localparam int rst_cycles  = 5;

   initial
   begin
      clk_o = 1'b0;
      forever #(half_period) clk_o = ~clk_o;
   end

   // reset drops just after a rising edge, like every other input.
   initial
   begin
      rst_o = 1'b1;
      repeat (rst_cycles) @(posedge clk_o);
      #1;
      rst_o = 1'b0;
   end

endmodule

// ==== tb_monitor.sv ====
`timescale 1ns/100ps

module tb_monitor (
   input  logic        wb_clk_i,
   input  logic        m_reset0,
   input  logic [3:0]  phase_i,
   input  logic        ss_xfer0_i,
   input  logic        ss_last0_i,
   input  logic [31:0] wbs_dat_o0_i,
   input  logic [31:0] wbs_dat64_o0_i,
   input  logic        m_src_getn0_i,
   input  logic        ss_xfer1_i,
   input  logic        m_dst_putn0_i,
   input  logic [63:0] m_dst0_i,
   input  logic        m_dst_last0_i,
   input  logic        m_endn0_i,
   input  logic        ss_stop0_i,
   input  logic        ss_start0_i,
   input  logic        ss_stop1_i,
   input  logic        ss_start1_i,
   input  logic        ss_end1_i,
   input  logic [31:0] wbs_dat_i1_i,
   input  logic [31:0] wbs_dat64_i1_i,
   input  logic [63:0] m_src0_i,
   input  logic        m_src_last0_i,
   input  logic        m_src_empty0_i,
   input  logic        m_src_aempty0_i,
   input  logic        m_dst_full0_i,
   input  logic        m_dst_afull0_i,
   input  logic [15:0] ocnt0_i,
   output int          data_errs_o,
   output int          flag_errs_o
);

   localparam int depth = 256;

   logic [71:0] src_q[$];                     // model of the source region.
   logic [71:0] dst_q[$];                     // model of the destination region.
   logic [71:0] src_next;
   logic [71:0] dst_next;
   logic [71:0] src_exp;                      // word last handed to the module.
   logic [71:0] dst_exp;                      // word last handed to stream 1.
   logic        src_pend;
   logic        dst_pend;
   logic        src_seen;
   logic        dst_seen;
   logic        src_wr;
   logic        dst_wr;
   logic        ref_end;
   logic [15:0] ref_ocnt;
   int          data_errs = 0;
   int          flag_errs = 0;

   assign data_errs_o = data_errs;
   assign flag_errs_o = flag_errs;

   // --------------------
   // reference functions
   // --------------------
   function automatic logic [71:0] pack_word(input logic last, input logic [63:0] d);
      return {last, 7'b0, d};                 // tag byte carries the last flag in bit 7.
   endfunction

   // {ss_stop0, ss_start0, empty, almost empty}.
   function automatic logic [3:0] src_flags(input int cnt);
      return {cnt >= 254, cnt < 128, cnt == 0, cnt <= 1};
   endfunction

   // {ss_stop1, ss_start1, full, almost full}.
   function automatic logic [3:0] dst_flags(input int cnt, input logic endn);
      return {cnt <= 1, (cnt >= 128) || (!endn && cnt != 0), cnt == depth, cnt >= 254};
   endfunction

   function automatic string phase_name(input logic [3:0] p);
      case (p)
         4'd1:    return "reset_state";
         4'd2:    return "src_order";
         4'd3:    return "src_fill";
         4'd4:    return "dst_path";
         4'd5:    return "end_flush";
         default: return "idle";
      endcase
   endfunction

   task automatic check_data(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
      if (act !== exp)
      begin
         data_errs++;
         $display("[ERROR] %s: %s expected %h actual %h", phase_name(phase_i), what, exp, act);
      end
   endtask

   task automatic check_flags(input string what, input logic [3:0] exp, input logic [3:0] act);
      if (act !== exp)
      begin
         flag_errs++;
         $display("[ERROR] %s: %s expected %b actual %b", phase_name(phase_i), what, exp, act);
      end
   endtask

   // --------------------
   // compare at the falling edge, where inputs and outputs are settled
   // --------------------
   always @(negedge wb_clk_i)
   begin
      if (m_reset0)
      begin
         src_q.delete();
         dst_q.delete();
         src_pend = 1'b0;
         dst_pend = 1'b0;
         src_seen = 1'b0;
         dst_seen = 1'b0;
         ref_end  = 1'b0;
         ref_ocnt = 16'd0;
      end
      else
      begin
         if (src_pend)
         begin
            src_exp  = src_next;              // read data shows one cycle after the get.
            src_seen = 1'b1;
         end
         if (dst_pend)
         begin
            dst_exp  = dst_next;
            ref_end  = dst_next[71];
            dst_seen = 1'b1;
         end
         if (src_seen)
         begin
            check_data("m_src0", src_exp[63:0], m_src0_i);
            check_data("m_src_last0", 64'(src_exp[71]), 64'(m_src_last0_i));
         end
         if (dst_seen)
         begin
            check_data("wbs_dat64_i1", 64'(dst_exp[63:32]), 64'(wbs_dat64_i1_i));
            check_data("wbs_dat_i1", 64'(dst_exp[31:0]), 64'(wbs_dat_i1_i));
         end
         check_data("ss_end1", 64'(ref_end), 64'(ss_end1_i));
         check_data("ocnt0", 64'(ref_ocnt), 64'(ocnt0_i));
         check_flags("source flags", src_flags(src_q.size()),
                     {ss_stop0_i, ss_start0_i, m_src_empty0_i, m_src_aempty0_i});
         check_flags("destination flags", dst_flags(dst_q.size(), m_endn0_i),
                     {ss_stop1_i, ss_start1_i, m_dst_full0_i, m_dst_afull0_i});

         // requests of this cycle take effect at the next rising edge.
         src_wr   = ss_xfer0_i && src_q.size() < depth;
         dst_wr   = !m_dst_putn0_i && dst_q.size() < depth;
         src_pend = !m_src_getn0_i && src_q.size() != 0 && !dst_wr;   // port B busy on a put.
         dst_pend = ss_xfer1_i && !ref_end && dst_q.size() != 0 && !src_wr;
         if (src_pend)
            src_next = src_q.pop_front();
         if (dst_pend)
            dst_next = dst_q.pop_front();
         if (src_wr)
            src_q.push_back(pack_word(ss_last0_i, {wbs_dat64_o0_i, wbs_dat_o0_i}));
         if (dst_wr)
         begin
            dst_q.push_back(pack_word(m_dst_last0_i, m_dst0_i));
            if (!m_dst_last0_i)
               ref_ocnt++;
         end
      end
   end

endmodule

// ==== tb_top.sv ====
`timescale 1ns/100ps

module tb_top;

   localparam int clk_period = 8;
   localparam int n_src      = 100;           // words in the ordering test.
   localparam int n_fill     = 300;           // words offered to a 256-deep region.
   localparam int n_dst      = 60;
   localparam int n_flush    = 20;
   // every word is written and read once, eight cycles each, plus a margin.
   localparam int wd_limit = ((n_src + n_fill + n_dst + n_flush) * 2 * 8 + 200) * clk_period;

   logic        wb_clk_i;
   logic        m_reset0;
   logic        ss_xfer0_i;
   logic        ss_last0_i;
   logic [31:0] wbs_dat_o0_i;
   logic [31:0] wbs_dat64_o0_i;
   logic        ss_stop0_o;
   logic        ss_start0_o;
   logic        ss_xfer1_i;
   logic        ss_stop1_o;
   logic        ss_start1_o;
   logic        ss_end1_o;
   logic [31:0] wbs_dat_i1_o;
   logic [31:0] wbs_dat64_i1_o;
   logic        m_src_getn0_i;
   logic [63:0] m_src0_o;
   logic        m_src_last0_o;
   logic        m_src_empty0_o;
   logic        m_src_almost_empty0_o;
   logic        m_dst_putn0_i;
   logic [63:0] m_dst0_i;
   logic        m_dst_last0_i;
   logic        m_endn0_i;
   logic        m_dst_full0_o;
   logic        m_dst_almost_full0_o;
   logic [15:0] ocnt0_o;
   logic [3:0]  phase;
   logic [31:0] seed;
   int          data_errs;
   int          flag_errs;

   tb_clkgen clkgen_i (
      .clk_o (wb_clk_i),
      .rst_o (m_reset0)
   );

   ch_dma_chan dut_i (.*);

   tb_monitor mon_i (
      .wb_clk_i        (wb_clk_i),
      .m_reset0        (m_reset0),
      .phase_i         (phase),
      .ss_xfer0_i      (ss_xfer0_i),
      .ss_last0_i      (ss_last0_i),
      .wbs_dat_o0_i    (wbs_dat_o0_i),
      .wbs_dat64_o0_i  (wbs_dat64_o0_i),
      .m_src_getn0_i   (m_src_getn0_i),
      .ss_xfer1_i      (ss_xfer1_i),
      .m_dst_putn0_i   (m_dst_putn0_i),
      .m_dst0_i        (m_dst0_i),
      .m_dst_last0_i   (m_dst_last0_i),
      .m_endn0_i       (m_endn0_i),
      .ss_stop0_i      (ss_stop0_o),
      .ss_start0_i     (ss_start0_o),
      .ss_stop1_i      (ss_stop1_o),
      .ss_start1_i     (ss_start1_o),
      .ss_end1_i       (ss_end1_o),
      .wbs_dat_i1_i    (wbs_dat_i1_o),
      .wbs_dat64_i1_i  (wbs_dat64_i1_o),
      .m_src0_i        (m_src0_o),
      .m_src_last0_i   (m_src_last0_o),
      .m_src_empty0_i  (m_src_empty0_o),
      .m_src_aempty0_i (m_src_almost_empty0_o),
      .m_dst_full0_i   (m_dst_full0_o),
      .m_dst_afull0_i  (m_dst_almost_full0_o),
      .ocnt0_i         (ocnt0_o),
      .data_errs_o     (data_errs),
      .flag_errs_o     (flag_errs)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // --------------------
   // stimulus tasks
   // --------------------
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge wb_clk_i);
      #1;
   endtask

   task automatic stream_words(input int n, input logic tag_last);
      for (int i = 0; i < n; i++)
      begin
         @(posedge wb_clk_i);
         #1;
         seed           = lcg_next(seed);
         wbs_dat_o0_i   = seed;
         seed           = lcg_next(seed);
         wbs_dat64_o0_i = seed;
         ss_last0_i     = tag_last && (i == n - 1);
         ss_xfer0_i     = 1'b1;
      end
      wait_cycles(1);
      ss_xfer0_i = 1'b0;
      ss_last0_i = 1'b0;
   endtask

   task automatic get_words(input int n);
      for (int i = 0; i < n; i++)
         wait_cycles(1);
      m_src_getn0_i = 1'b1;
   endtask

   task automatic put_results(input int n, input logic tag_last);
      for (int i = 0; i < n; i++)
      begin
         @(posedge wb_clk_i);
         #1;
         seed           = lcg_next(seed);
         m_dst0_i[63:32] = seed;
         seed           = lcg_next(seed);
         m_dst0_i[31:0]  = seed;
         m_dst_last0_i  = tag_last && (i == n - 1);
         m_dst_putn0_i  = 1'b0;
      end
      wait_cycles(1);
      m_dst_putn0_i = 1'b1;
      m_dst_last0_i = 1'b0;
   endtask

   // stream 1 keeps pulling until the tagged word shows up.
   task automatic read_until_end();
      wait_cycles(1);
      ss_xfer1_i = 1'b1;
      while (!ss_end1_o)
         wait_cycles(1);
      ss_xfer1_i = 1'b0;
   endtask

   initial
   begin
      phase          = 4'd0;
      seed           = 32'hbbb1;
      ss_xfer0_i     = 1'b0;
      ss_last0_i     = 1'b0;
      wbs_dat_o0_i   = 32'd0;
      wbs_dat64_o0_i = 32'd0;
      ss_xfer1_i     = 1'b0;
      m_src_getn0_i  = 1'b1;
      m_dst_putn0_i  = 1'b1;
      m_dst0_i       = 64'd0;
      m_dst_last0_i  = 1'b0;
      m_endn0_i      = 1'b1;
      wait (!m_reset0);
      phase = 4'd1;
      wait_cycles(3);
      phase = 4'd2;
      stream_words(n_src, 1'b1);
      m_src_getn0_i = 1'b0;
      get_words(n_src);
      phase = 4'd3;
      stream_words(n_fill, 1'b0);             // the words past 256 are dropped.
      m_src_getn0_i = 1'b0;
      get_words(260);
      phase = 4'd4;
      put_results(n_dst, 1'b1);
      read_until_end();
      wait_cycles(2);
      phase = 4'd5;
      put_results(n_flush, 1'b0);
      wait_cycles(2);
      m_endn0_i  = 1'b0;
      ss_xfer1_i = 1'b1;                      // blocked, the tagged word already left.
      wait_cycles(8);
      ss_xfer1_i = 1'b0;
      wait_cycles(4);
      $display("errors: data %0d, flags %0d", data_errs, flag_errs);
      if (data_errs + flag_errs == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      #(wd_limit);
      $display("watchdog: run did not finish within %0d ns, stuck in phase %0d", wd_limit, phase);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule
